/* source/sha1_pkg.sv */
`default_nettype none

package sha1_pkg;

	// Algorithm sizes fixed by the standard
	localparam int word_bits    = 32;
	localparam int block_words  = 16;
	localparam int digest_words = 5;

	typedef logic [word_bits-1:0]              word_t;
	typedef logic [block_words*word_bits-1:0]  block_t;
	typedef logic [digest_words*word_bits-1:0] digest_t;

	// One of the four groups of twenty rounds
	typedef logic [1:0] group_t;

	// H0 in the top lane down to H4 in the bottom lane
	localparam digest_t init_hash = {
		32'h67452301,
		32'hEFCDAB89,
		32'h98BADCFE,
		32'h10325476,
		32'hC3D2E1F0
	};

	// Indexed by round group
	localparam word_t k_const [4] = '{
		32'h5A827999,
		32'h6ED9EBA1,
		32'h8F1BBCDC,
		32'hCA62C1D6
	};

	localparam int round_count = 80;
	localparam int group_len   = 20;

endpackage

`default_nettype wire

/* source/sha1_ctrl_pkg.sv */
`default_nettype none

package sha1_ctrl_pkg;

	// Round index, 0 to 79
	typedef logic [6:0] round_t;

	// Schedule FSM
	typedef enum logic [1:0]
	{
		st_idle,
		st_load,
		st_run
	} sched_state_t;

endpackage

`default_nettype wire

/* source/sha1_schedule.sv */
`default_nettype none
`timescale 1ns/10ps

module sha1_schedule (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  start,
	input  sha1_pkg::block_t      block,
	output logic                  busy,
	output logic                  load,
	output logic                  round_en,
	output sha1_ctrl_pkg::round_t round,
	output sha1_pkg::word_t       w,
	output logic                  finish
);

	import sha1_pkg::*;
	import sha1_ctrl_pkg::*;

	sched_state_t state;
	sched_state_t state_next;
	logic         accept;
	logic         last_round;
	logic         expand;
	word_t        sched_q [block_words];
	word_t        mix;
	word_t        w_exp;

	////////////////////////////////////////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////////////////////////////////////////

	// Starts while busy are dropped
	assign accept     = start && !busy;
	assign last_round = (round == round_t'(round_count - 1));

	always_comb
	begin
		state_next = state;
		case (state)
			st_idle:
				if (accept)
					state_next = st_load;
			st_load:
				state_next = st_run;
			st_run:
				if (last_round)
					state_next = st_idle;
			default:
				state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= st_idle;
		else
			state <= state_next;
	end

	assign load     = (state == st_load);
	assign round_en = (state == st_run);

	always_ff @(posedge clk)
	begin
		if (reset)
			round <= '0;
		else if (load)
			round <= '0;
		else if (round_en && !last_round)
			round <= round + round_t'(1);
	end

	// Finish follows the last round and clears busy
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			finish <= 1'b0;
			busy   <= 1'b0;
		end
		else
		begin
			finish <= round_en && last_round;
			if (accept)
				busy <= 1'b1;
			else if (finish)
				busy <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Message schedule
	////////////////////////////////////////////////////////////////////////////

	// sched_q[0] is sixteen words back once expansion starts
	assign expand = (round >= round_t'(block_words));
	assign mix    = sched_q[block_words - 3] ^ sched_q[block_words - 8]
		^ sched_q[block_words - 14] ^ sched_q[0];
	assign w_exp  = {mix[word_bits-2:0], mix[word_bits-1]};
	assign w      = expand ? w_exp : sched_q[0];

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			// Word 0 sits in the top bits of the block
			for (int i = 0; i < block_words; i++)
				sched_q[i] <= block[(block_words - 1 - i) * word_bits +: word_bits];
		end
		else if (round_en)
		begin
			for (int i = 0; i < block_words - 1; i++)
				sched_q[i] <= sched_q[i + 1];
			sched_q[block_words - 1] <= w;
		end
	end

	round_in_range: assert property (
		@(posedge clk) disable iff (reset)
		round_en |-> (round < round_t'(round_count))
	);

	// A new block never loads over one still in its rounds
	accept_when_idle: assert property (
		@(posedge clk) disable iff (reset)
		accept |-> (!load && !round_en)
	);

endmodule

`default_nettype wire

/* source/sha1_round.sv */
`default_nettype none
`timescale 1ns/10ps

module sha1_round (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  load,
	input  logic                  round_en,
	input  sha1_ctrl_pkg::round_t round,
	input  sha1_pkg::word_t       w,
	output sha1_pkg::digest_t     work
);

	import sha1_pkg::*;

	group_t rnd_group;
	word_t  a;
	word_t  b;
	word_t  c;
	word_t  d;
	word_t  e;
	word_t  f;
	word_t  k;
	word_t  a_rot5;
	word_t  b_rot30;
	word_t  a_next;

	assign {a, b, c, d, e} = work;

	////////////////////////////////////////////////////////////////////////////
	// Round function and constant
	////////////////////////////////////////////////////////////////////////////

	assign rnd_group = group_t'(round / group_len);
	assign k         = k_const[rnd_group];

	always_comb
	begin
		case (rnd_group)
			2'd0:
				f = (b & c) | (~b & d);
			2'd2:
				f = (b & c) | (b & d) | (c & d);
			// Parity in groups 1 and 3
			default:
				f = b ^ c ^ d;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Working variables
	////////////////////////////////////////////////////////////////////////////

	assign a_rot5  = {a[word_bits-6:0], a[word_bits-1:word_bits-5]};
	assign b_rot30 = {b[1:0], b[word_bits-1:2]};
	assign a_next  = a_rot5 + f + e + k + w;

	always_ff @(posedge clk)
	begin
		if (reset)
			work <= '0;
		else if (load)
			work <= init_hash;
		else if (round_en)
			work <= {a_next, a, b_rot30, c, d};
	end

endmodule

`default_nettype wire

/* source/sha1_digest.sv */
`default_nettype none
`timescale 1ns/10ps

module sha1_digest (
	input  logic              clk,
	input  logic              reset,
	input  logic              finish,
	input  sha1_pkg::digest_t work,
	output sha1_pkg::digest_t hash,
	output logic              done
);

	import sha1_pkg::*;

	digest_t sum;

	// Each lane wraps at 32 bits
	always_comb
	begin
		for (int i = 0; i < digest_words; i++)
			sum[i*word_bits +: word_bits] = init_hash[i*word_bits +: word_bits]
				+ work[i*word_bits +: word_bits];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hash <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= finish;
			if (finish)
				hash <= sum;
		end
	end

	// Only one block is ever in flight
	done_single_pulse: assert property (
		@(posedge clk) disable iff (reset)
		done |=> !done
	);

endmodule

`default_nettype wire

/* source/sha1_core.sv */
`default_nettype none
`timescale 1ns/10ps

module sha1_core (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  sha1_pkg::block_t  block,
	output logic              busy,
	output logic              done,
	output sha1_pkg::digest_t hash
);

	import sha1_pkg::*;
	import sha1_ctrl_pkg::*;

	logic    load;
	logic    round_en;
	logic    finish;
	round_t  round;
	word_t   w;
	digest_t work;

	// Decode
	sha1_schedule schedule_i (
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.block    (block),
		.busy     (busy),
		.load     (load),
		.round_en (round_en),
		.round    (round),
		.w        (w),
		.finish   (finish)
	);

	// Execute
	sha1_round round_i (
		.clk      (clk),
		.reset    (reset),
		.load     (load),
		.round_en (round_en),
		.round    (round),
		.w        (w),
		.work     (work)
	);

	// Result
	sha1_digest digest_i (
		.clk      (clk),
		.reset    (reset),
		.finish   (finish),
		.work     (work),
		.hash     (hash),
		.done     (done)
	);

endmodule

`default_nettype wire

/* test/sha1_checker.sv */
`default_nettype none
`timescale 1ns/10ps

module sha1_checker (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  sha1_pkg::block_t  block,
	input  logic              busy,
	input  logic              done,
	input  sha1_pkg::digest_t hash,
	input  logic              closing,
	input  int                expected_dones,
	output int                value_errors,
	output int                protocol_errors
);

	import sha1_pkg::*;

	// Done is set 82 edges after the accepting edge and sampled one edge later
	localparam int done_age = 83;

	localparam block_t  abc_block  = {32'h61626380, {14{32'h00000000}}, 32'h00000018};
	localparam digest_t abc_digest = 160'ha9993e36_4706816a_ba3e2571_7850c26c_9cd0d89d;

	digest_t expected_q [$];
	digest_t held_hash      = '0;
	int      value_count    = 0;
	int      protocol_count = 0;
	int      cycle          = 0;
	int      accept_cycle   = 0;
	int      dones_seen     = 0;
	logic    in_flight      = 1'b0;
	logic    prev_reset     = 1'b0;
	logic    model_checked  = 1'b0;
	logic    closed         = 1'b0;

	assign value_errors    = value_count;
	assign protocol_errors = protocol_count;

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic word_t rotl(input word_t x, input int n);
		return (x << n) | (x >> (32 - n));
	endfunction

	function automatic digest_t model_sha1(input block_t blk);
		word_t ws [80];
		word_t a, b, c, d, e;
		word_t f;
		word_t k;
		word_t t_sum;
		for (int t = 0; t < 16; t++)
			ws[t] = blk[(15 - t) * 32 +: 32];
		for (int t = 16; t < 80; t++)
			ws[t] = rotl(ws[t-3] ^ ws[t-8] ^ ws[t-14] ^ ws[t-16], 1);
		{a, b, c, d, e} = init_hash;
		for (int t = 0; t < 80; t++)
		begin
			if (t < 20)
			begin
				f = (b & c) | (~b & d);
				k = k_const[0];
			end
			else if (t < 40)
			begin
				f = b ^ c ^ d;
				k = k_const[1];
			end
			else if (t < 60)
			begin
				f = (b & c) | (b & d) | (c & d);
				k = k_const[2];
			end
			else
			begin
				f = b ^ c ^ d;
				k = k_const[3];
			end
			t_sum = rotl(a, 5) + f + e + k + ws[t];
			e = d;
			d = c;
			c = rotl(b, 30);
			b = a;
			a = t_sum;
		end
		return {a + init_hash[159:128], b + init_hash[127:96], c + init_hash[95:64],
			d + init_hash[63:32], e + init_hash[31:0]};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Port monitor
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin : monitor
		digest_t expected;
		logic    done_due;
		cycle++;

		if (!model_checked)
		begin
			model_checked = 1'b1;
			if (model_sha1(abc_block) !== abc_digest)
			begin
				value_count++;
				$display("[ERROR] %0d ns: model digest of abc is %h, expected %h",
					$time, model_sha1(abc_block), abc_digest);
			end
		end

		// Outputs as left by a reset edge
		if (prev_reset && (busy !== 1'b0 || done !== 1'b0 || hash !== '0))
		begin
			value_count++;
			$display("[ERROR] %0d ns: busy %b done %b hash %h after reset",
				$time, busy, done, hash);
		end
		prev_reset = reset;

		if (reset)
		begin
			in_flight = 1'b0;
			held_hash = '0;
			expected_q.delete();
		end
		else
		begin
			done_due = in_flight && (cycle - accept_cycle == done_age);
			if (in_flight && !done_due && busy !== 1'b1)
			begin
				protocol_count++;
				$display("Busy went low at %0d ns while a block was in flight", $time);
			end
			if (done === 1'b1)
			begin
				dones_seen++;
				if (expected_q.size() == 0)
				begin
					protocol_count++;
					$display("Done pulse at %0d ns with no block pending", $time);
				end
				else
				begin
					if (!done_due)
					begin
						protocol_count++;
						$display("Done pulse at %0d ns came at the wrong edge", $time);
					end
					expected = expected_q.pop_front();
					if (hash !== expected)
					begin
						value_count++;
						$display("[ERROR] %0d ns: hash %h, expected %h", $time, hash, expected);
					end
				end
			end
			else if (done_due)
			begin
				protocol_count++;
				$display("Missing done pulse at %0d ns, 82 edges after an accepted start",
					$time);
				if (expected_q.size() != 0)
					expected = expected_q.pop_front();
			end
			// Hash holds between done pulses
			if (done !== 1'b1 && hash !== held_hash)
			begin
				value_count++;
				$display("[ERROR] %0d ns: hash changed to %h between done pulses",
					$time, hash);
			end
			held_hash = hash;
			if (done_due)
			begin
				in_flight = 1'b0;
				if (busy !== 1'b0)
				begin
					protocol_count++;
					$display("Busy still high at %0d ns in the done cycle", $time);
				end
			end
			// Start taken while idle
			if (start === 1'b1 && busy === 1'b0)
			begin
				expected_q.push_back(model_sha1(block));
				accept_cycle = cycle;
				in_flight    = 1'b1;
			end
		end

		if (closing && !closed)
		begin
			closed = 1'b1;
			if (expected_q.size() != 0)
			begin
				protocol_count++;
				$display("%0d accepted blocks never completed", expected_q.size());
			end
			if (dones_seen != expected_dones)
			begin
				protocol_count++;
				$display("Saw %0d done pulses, expected %0d", dones_seen, expected_dones);
			end
		end
	end

endmodule

`default_nettype wire

/* test/sha1_core_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module sha1_core_tb;

	import sha1_pkg::*;

	localparam int clk_period    = 40;
	localparam int reset_cycles  = 16;
	localparam int random_blocks = 24;
	localparam int done_latency  = 82;
	// abc, the random run, the ignored start pair and the back to back pair
	localparam int launches      = 1 + random_blocks + 2 + 2;
	localparam int timeout_ns    = (launches * 100 + reset_cycles) * clk_period;

	localparam block_t abc_block = {32'h61626380, {14{32'h00000000}}, 32'h00000018};

	logic    clk;
	logic    reset;
	logic    start;
	block_t  block;
	logic    busy;
	logic    done;
	digest_t hash;
	logic    closing;
	int      expected_dones;
	int      value_errors;
	int      protocol_errors;
	integer  seed;
	block_t  blk_a;
	block_t  blk_b;
	int      gap;

	sha1_core sha1_core_i (
		.clk   (clk),
		.reset (reset),
		.start (start),
		.block (block),
		.busy  (busy),
		.done  (done),
		.hash  (hash)
	);

	sha1_checker checker_i (
		.clk             (clk),
		.reset           (reset),
		.start           (start),
		.block           (block),
		.busy            (busy),
		.done            (done),
		.hash            (hash),
		.closing         (closing),
		.expected_dones  (expected_dones),
		.value_errors    (value_errors),
		.protocol_errors (protocol_errors)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(clk_period / 2) clk = ~clk;
	end

	initial
	begin
		#(timeout_ns);
		$display("Timeout: the run did not finish within %0d ns", timeout_ns);
		$display("** FAIL **");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic make_random_block(output block_t blk);
		for (int i = 0; i < 16; i++)
			blk[i*32 +: 32] = $random(seed);
	endtask

	// Waits for idle, then pulses start for one cycle
	task automatic send_block(input block_t blk);
		@(posedge clk);
		while (busy)
			@(posedge clk);
		start <= 1'b1;
		block <= blk;
		expected_dones++;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_done();
		@(posedge clk);
		while (done !== 1'b1)
			@(posedge clk);
	endtask

	initial
	begin
		seed           = 32'had98;
		expected_dones = 0;
		reset   <= 1'b1;
		start   <= 1'b0;
		block   <= '0;
		closing <= 1'b0;
		repeat (reset_cycles)
			@(posedge clk);
		reset <= 1'b0;

		// Known vector
		send_block(abc_block);
		wait_done();

		for (int n = 0; n < random_blocks; n++)
		begin
			make_random_block(blk_a);
			gap = $random(seed) & 7;
			repeat (gap)
				@(posedge clk);
			send_block(blk_a);
			wait_done();
		end

		// Second start lands mid block and is dropped
		make_random_block(blk_a);
		make_random_block(blk_b);
		send_block(blk_a);
		repeat (10)
			@(posedge clk);
		start <= 1'b1;
		block <= blk_b;
		@(posedge clk);
		start <= 1'b0;
		wait_done();

		// Next start in the done cycle
		make_random_block(blk_a);
		make_random_block(blk_b);
		send_block(blk_a);
		repeat (done_latency)
			@(posedge clk);
		start <= 1'b1;
		block <= blk_b;
		expected_dones++;
		@(posedge clk);
		start <= 1'b0;
		wait_done();

		repeat (8)
			@(posedge clk);
		closing <= 1'b1;
		repeat (2)
			@(posedge clk);
		$display("Closing report: %0d value errors, %0d protocol errors, %0d blocks expected",
			value_errors, protocol_errors, expected_dones);
		if (value_errors == 0 && protocol_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

/* sha1_core.f */
source/sha1_pkg.sv
source/sha1_ctrl_pkg.sv
source/sha1_schedule.sv
source/sha1_round.sv
source/sha1_digest.sv
source/sha1_core.sv
test/sha1_checker.sv
test/sha1_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the SHA-1 core testbench with Verilator, run it, and search the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sha1_core.f --top-module sha1_core_tb -o sha1_sim \
	&& ./obj_dir/sha1_sim > sim.log 2>&1 \
	|| { echo "Build or simulation run failed"; [ -f sim.log ] && cat sim.log; exit 1; }

cat sim.log

grep -qx '\*\* PASS \*\*' sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
